// File: common/exStage_defs.svh
/*
 * EX1 stage constants
 * widths, register ids, memory op codes, ixt sub-op codes and trap codes
 */
`ifndef EX_STAGE_DEFS_SVH
`define EX_STAGE_DEFS_SVH

// datapath and address widths
`define EX_XLEN          64
`define EX_VALEN         48
`define EX_REGID_W       6

// register ids
`define EX_GR_ZZR        6'h3F
`define EX_GR_LR         6'h2E
`define EX_CR_PC         6'h00

// memory op codes and status
`define EX_OPM_READY     5'h00
`define EX_OPM_TRAP      5'h1F
`define EX_MEMOK_HOLD    2'b10

// OP_IXT sub-ops
`define EX_IXT_NOP       6'h00
`define EX_IXT_CLRT      6'h04
`define EX_IXT_SETT      6'h05
`define EX_IXT_CLRS      6'h06
`define EX_IXT_SETS      6'h07
`define EX_IXT_NOTT      6'h08
`define EX_IXT_NOTS      6'h09
`define EX_IXT_RTE       6'h0C
`define EX_IXT_TRAPA     6'h0E
`define EX_IXT_SYSE      6'h0F

// OP_IXS sub-ops
`define EX_IXS_NOP       6'h00
`define EX_IXS_MOVT      6'h01
`define EX_IXS_MOVNT     6'h02
`define EX_IXS_TRAPB     6'h04

// trap codes
`define EX_TRAP_RTE      16'hFF00
`define EX_TRAP_TRAPA_HI 12'hC08
`define EX_TRAP_SYSE_HI  4'hE

`endif

// File: common/exPkg.sv
/*
 * EX1 stage package
 * micro-op encodings and the packed bundles passed between the stage units
 */
`default_nettype none
`include "exStage_defs.svh"

package exPkg;

	// decoded micro-op command
	typedef enum logic [5:0] {
		NOP    = 6'h00,
		INVOP  = 6'h01,
		LEA    = 6'h02,
		MOV_RM = 6'h03,
		MOV_MR = 6'h04,
		ALU3   = 6'h05,
		MOV_CR = 6'h06,
		MOV_IR = 6'h07,
		BRA    = 6'h08,
		BRA_NB = 6'h09,
		BSR    = 6'h0A,
		JMP    = 6'h0B,
		JSR    = 6'h0C,
		OP_IXS = 6'h0D,
		OP_IXT = 6'h0E
	} exUCmd_e;

	// predication against SR.T
	typedef enum logic [1:0] {
		AL = 2'b00,
		NV = 2'b01,
		CT = 2'b10,
		CF = 2'b11
	} exCc_e;

	typedef struct packed {
		exCc_e      cc;
		exUCmd_e    cmd;
		logic [7:0] ixt;
	} exOp_t;

	// register ids and values read by decode
	typedef struct packed {
		logic [`EX_REGID_W-1:0] rsId;
		logic [`EX_REGID_W-1:0] rtId;
		logic [`EX_REGID_W-1:0] rmId;
		logic [`EX_XLEN-1:0]    rsVal;
		logic [`EX_XLEN-1:0]    rtVal;
		logic [`EX_XLEN-1:0]    rmVal;
		logic [`EX_XLEN-1:0]    crmVal;
	} exSrc_t;

	// architectural context
	typedef struct packed {
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] sr;
		logic [`EX_XLEN-1:0] dlr;
		logic [`EX_XLEN-1:0] lr;
	} exCtx_t;

	typedef struct packed {
		logic                doBra;
		logic [`EX_XLEN-1:0] target;
	} exBranch_t;

	typedef struct packed {
		logic [`EX_VALEN-1:0] addr;
		logic [4:0]           opm;
		logic [`EX_XLEN-1:0]  data;
		logic [`EX_XLEN-1:0]  dataB;
	} exMemReq_t;

	typedef struct packed {
		logic [`EX_REGID_W-1:0] id;
		logic [`EX_XLEN-1:0]    value;
	} exWb_t;

	typedef struct packed {
		logic regHeld;
		logic exHold;
	} exStall_t;

endpackage

`default_nettype wire

// File: hdl/exOpGate.sv
/*
 * EX1 op gate
 * condition-code predication and branch flush, yields the effective command
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exOpGate (
	input  exPkg::exOp_t     op,
	input  wire              srT,
	input  wire              braFlush,
	output exPkg::exUCmd_e   cmd
);
	import exPkg::*;

	logic opEnable;

	always_comb begin
		case (op.cc)
			AL: opEnable = 1'b1;
			NV: opEnable = 1'b0;
			CT: opEnable = srT;
			CF: opEnable = !srT;
			default: opEnable = 1'b0;
		endcase
		// flush kills everything
		if (braFlush)
			opEnable = 1'b0;
	end

	// a skipped BRA still has to undo a taken prediction
	always_comb begin
		if (opEnable)
			cmd = op.cmd;
		else if ((op.cmd == BRA) && !braFlush)
			cmd = BRA_NB;
		else
			cmd = NOP;
	end

endmodule

`default_nettype wire

// File: hdl/exAgu.sv
/*
 * EX1 address generator
 * scaled base plus index, upper bits from the PC unless the address-mode flag is set
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exAgu (
	input  wire                        clock,
	input  wire                        rstN,
	input  wire [`EX_VALEN-1:0]        base,
	input  wire [`EX_VALEN-1:0]        index,
	input  wire [7:0]                  ixt,
	input  wire                        srJq,
	input  wire [`EX_VALEN-33:0]       pcHi,
	output logic [`EX_VALEN-1:0]       addr
);

	// registered copy of SR bit 31
	logic aguJq;
	logic [`EX_VALEN-1:0] scaledIndex;
	logic [`EX_VALEN-1:0] sum;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			aguJq <= 1'b0;
		else
			aguJq <= srJq;
	end

	// scale 1/2/4/8 from ixt[5:4]
	assign scaledIndex = index << ixt[5:4];
	assign sum = base + scaledIndex;

	always_comb begin
		addr = sum;
		// 32-bit mode keeps the current segment of the PC
		if (!aguJq)
			addr[`EX_VALEN-1:32] = pcHi;
	end

	aguJqResetLow: assert property (@(posedge clock) !rstN |-> (aguJq == 1'b0))
		else $error("address-mode flag set while in reset");

endmodule

`default_nettype wire

// File: hdl/branch/exBranchUnit.sv
/*
 * EX1 branch unit
 * branch targets, taken decision against the fetch prediction, link register update
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exBranchUnit (
	input  wire                         clock,
	input  exPkg::exUCmd_e              cmd,
	input  wire [`EX_XLEN-1:0]          pc,
	input  wire [`EX_XLEN-1:0]          rsVal,
	input  wire [`EX_REGID_W-1:0]       rsId,
	input  wire [`EX_XLEN-1:0]          disp,
	input  wire [1:0]                   preBra,
	input  wire [`EX_XLEN-1:0]          lr,
	output exPkg::exBranch_t            branch,
	output logic [`EX_XLEN-1:0]         lrOut
);
	import exPkg::*;

	logic [`EX_VALEN-1:0] braLo;
	logic [`EX_XLEN-1:0] braTarget;
	logic [`EX_XLEN-1:0] jmpTarget;

	// pc-relative, displacement counts 16-bit units
	assign braLo = pc[`EX_VALEN-1:0] + {disp[`EX_VALEN-2:0], 1'b0};
	assign braTarget = {pc[`EX_XLEN-1:`EX_VALEN], braLo};

	// register jump
	always_comb begin
		jmpTarget = {pc[`EX_XLEN-1:`EX_VALEN], rsVal[`EX_VALEN-1:0]};
		// a saved LR carries its own upper bits
		if (rsId == `EX_GR_LR)
			jmpTarget[`EX_XLEN-1:`EX_VALEN] = rsVal[`EX_XLEN-1:`EX_VALEN];
	end

	always_comb begin
		branch.doBra = 1'b0;
		branch.target = pc;
		lrOut = lr;
		case (cmd)
			BRA: begin
				branch.doBra = (preBra != 2'b01);
				branch.target = braTarget;
			end
			// fetch guessed taken, go back to the fall-through pc
			BRA_NB: begin
				branch.doBra = (preBra != 2'b00);
				branch.target = pc;
			end
			BSR: begin
				branch.doBra = (preBra != 2'b01);
				branch.target = braTarget;
				lrOut = pc;
			end
			JMP: begin
				branch.doBra = (preBra != 2'b01);
				branch.target = jmpTarget;
			end
			// call through register, never predicted
			JSR: begin
				branch.doBra = 1'b1;
				branch.target = jmpTarget;
				lrOut = pc;
			end
			default: begin
			end
		endcase
	end

	// pc and register targets must stay on 16-bit boundaries
	braTargetEven: assert property (@(posedge clock) branch.doBra |-> !branch.target[0])
		else $error("taken branch to odd address %h", branch.target);

endmodule

`default_nettype wire

// File: hdl/exSysOps.sv
/*
 * EX1 system ops
 * status register flag ops, T-bit moves and trap code generation
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exSysOps (
	input  exPkg::exUCmd_e              cmd,
	input  wire [7:0]                   ixt,
	input  wire [`EX_XLEN-1:0]          sr,
	input  wire [`EX_REGID_W-1:0]       rmId,
	input  wire [`EX_XLEN-1:0]          dlr,
	output logic [`EX_XLEN-1:0]         srOut,
	output logic [15:0]                 trapExc,
	output logic [`EX_XLEN-1:0]         tVal,
	output logic                        tValid,
	output logic                        unknownIxt
);
	import exPkg::*;

	always_comb begin
		srOut = sr;
		trapExc = 16'h0000;
		tVal = {{(`EX_XLEN-1){1'b0}}, sr[0]};
		tValid = 1'b0;
		unknownIxt = 1'b0;
		if (cmd == OP_IXT) begin
			case (ixt[5:0])
				`EX_IXT_NOP: begin
				end
				// T is bit 0, S is bit 1
				`EX_IXT_CLRT: srOut[0] = 1'b0;
				`EX_IXT_SETT: srOut[0] = 1'b1;
				`EX_IXT_NOTT: srOut[0] = !sr[0];
				`EX_IXT_CLRS: srOut[1] = 1'b0;
				`EX_IXT_SETS: srOut[1] = 1'b1;
				`EX_IXT_NOTS: srOut[1] = !sr[1];
				`EX_IXT_RTE: trapExc = `EX_TRAP_RTE;
				// vector number from the low bits of the Rm field
				`EX_IXT_TRAPA: trapExc = {`EX_TRAP_TRAPA_HI, rmId[3:0]};
				// syscall number passed in DLR
				`EX_IXT_SYSE: trapExc = {`EX_TRAP_SYSE_HI, dlr[11:0]};
				default: unknownIxt = 1'b1;
			endcase
		end else if (cmd == OP_IXS) begin
			case (ixt[5:0])
				`EX_IXS_NOP: begin
				end
				`EX_IXS_MOVT: tValid = 1'b1;
				`EX_IXS_MOVNT: begin
					tVal = {{(`EX_XLEN-1){1'b0}}, !sr[0]};
					tValid = 1'b1;
				end
				// handled by the memory issue unit
				`EX_IXS_TRAPB: begin
				end
				default: unknownIxt = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/exMemIssue.sv
/*
 * EX1 memory issue
 * encodes the load/store request and raises a hold while memory is busy
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exMemIssue (
	input  wire                         clock,
	input  exPkg::exUCmd_e              cmd,
	input  wire [7:0]                   ixt,
	input  wire [`EX_VALEN-1:0]         addr,
	input  wire [`EX_XLEN-1:0]          rmVal,
	input  wire [`EX_XLEN-1:0]          rtVal,
	input  wire [1:0]                   memOk,
	output exPkg::exMemReq_t            memReq,
	output logic                        memHold,
	output logic                        isLoad
);
	import exPkg::*;

	always_comb begin
		memReq.addr = addr;
		memReq.opm = `EX_OPM_READY;
		// store data from Rm, second word from Rt
		memReq.data = rmVal;
		memReq.dataB = rtVal;
		isLoad = 1'b0;
		case (cmd)
			// ixt[2] sign/unsigned, ixt[5:4] size
			MOV_RM: memReq.opm = {2'b10, ixt[2], ixt[5:4]};
			MOV_MR: begin
				memReq.opm = {2'b01, ixt[2], ixt[5:4]};
				isLoad = 1'b1;
			end
			OP_IXS: begin
				if (ixt[5:0] == `EX_IXS_TRAPB)
					memReq.opm = `EX_OPM_TRAP;
			end
			default: begin
			end
		endcase
	end

	// request repeats until memory leaves HOLD
	assign memHold = (memReq.opm != `EX_OPM_READY) && (memOk == `EX_MEMOK_HOLD);

	readyNoHold: assert property (@(posedge clock)
		(memReq.opm == `EX_OPM_READY) |-> !memHold)
		else $error("hold raised with no live request");

endmodule

`default_nettype wire

// File: hdl/exResultMux.sv
/*
 * EX1 result selector
 * GPR and control writeback, held destination, stall and flush squash
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exResultMux (
	input  exPkg::exUCmd_e              cmd,
	input  wire [7:0]                   ixt,
	input  exPkg::exSrc_t               src,
	input  wire [`EX_VALEN-1:0]         addr,
	input  wire [`EX_XLEN-1:0]          tVal,
	input  wire                         tValid,
	input  exPkg::exBranch_t            branch,
	input  wire                         memHold,
	input  wire                         isLoad,
	input  wire                         unknownIxt,
	input  wire                         braFlush,
	output exPkg::exWb_t                rn1,
	output exPkg::exWb_t                cn1,
	output logic [`EX_REGID_W-1:0]      heldId,
	output exPkg::exStall_t             stall
);
	import exPkg::*;

	always_comb begin
		rn1.id = `EX_GR_ZZR;
		rn1.value = '0;
		cn1.id = `EX_GR_ZZR;
		cn1.value = '0;
		case (cmd)
			LEA: begin
				rn1.id = src.rmId;
				rn1.value = {{(`EX_XLEN-`EX_VALEN){1'b0}}, addr};
			end
			MOV_CR: begin
				rn1.id = src.rmId;
				rn1.value = src.crmVal;
			end
			// immediate in Rt, shift-in forms append to Rs
			MOV_IR: begin
				rn1.id = src.rmId;
				case (ixt[3:0])
					4'h1: rn1.value = {src.rsVal[55:0], src.rtVal[7:0]};
					4'h2: rn1.value = {src.rsVal[47:0], src.rtVal[15:0]};
					4'h3: rn1.value = {src.rsVal[31:0], src.rtVal[31:0]};
					default: rn1.value = src.rtVal;
				endcase
			end
			default: begin
			end
		endcase
		// MOVT / MOVNT
		if (tValid) begin
			rn1.id = src.rmId;
			rn1.value = tVal;
		end
		// redirect goes out through the PC slot
		if (branch.doBra) begin
			cn1.id = `EX_CR_PC;
			cn1.value = branch.target;
		end
		if (braFlush) begin
			rn1.id = `EX_GR_ZZR;
			cn1.id = `EX_GR_ZZR;
		end
	end

	// result arrives in a later stage
	assign stall.regHeld = isLoad || (cmd == ALU3);
	assign heldId = stall.regHeld ? src.rmId : `EX_GR_ZZR;

	assign stall.exHold = (cmd == INVOP) || unknownIxt || memHold;

endmodule

`default_nettype wire

// File: hdl/exStage1.sv
/*
 * EX1 stage top
 * predicates the micro-op and ties the AGU, branch, system and memory units to writeback
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module exStage1 (
	input  wire                           clock,
	input  wire                           rstN,
	input  exPkg::exOp_t                  op,
	input  exPkg::exSrc_t                 src,
	input  exPkg::exCtx_t                 ctx,
	input  wire                           braFlush,
	input  wire [1:0]                     preBra,
	input  wire [1:0]                     memOk,
	output exPkg::exWb_t                  rn1,
	output exPkg::exWb_t                  cn1,
	output logic [`EX_REGID_W-1:0]        heldId,
	output logic [`EX_XLEN-1:0]           srOut,
	output logic [`EX_XLEN-1:0]           lrOut,
	output logic [15:0]                   trapExc,
	output exPkg::exMemReq_t              memReq,
	output exPkg::exStall_t               stall
);
	import exPkg::*;

	// effective command after predication
	exUCmd_e cmd;
	logic [`EX_VALEN-1:0] addr;
	exBranch_t branch;
	logic [`EX_XLEN-1:0] tVal;
	logic tValid;
	logic unknownIxt;
	logic memHold;
	logic isLoad;

	exOpGate exOpGate_inst (
		.op(op), .srT(ctx.sr[0]), .braFlush(braFlush), .cmd(cmd)
	);

	// flag tracks SR bit 31 one cycle late
	exAgu exAgu_inst (
		.clock(clock), .rstN(rstN),
		.base(src.rsVal[`EX_VALEN-1:0]), .index(src.rtVal[`EX_VALEN-1:0]),
		.ixt(op.ixt), .srJq(ctx.sr[31]), .pcHi(ctx.pc[`EX_VALEN-1:32]),
		.addr(addr)
	);

	// displacement arrives in Rt
	exBranchUnit exBranchUnit_inst (
		.clock(clock), .cmd(cmd), .pc(ctx.pc), .rsVal(src.rsVal), .rsId(src.rsId),
		.disp(src.rtVal), .preBra(preBra), .lr(ctx.lr),
		.branch(branch), .lrOut(lrOut)
	);

	exSysOps exSysOps_inst (
		.cmd(cmd), .ixt(op.ixt), .sr(ctx.sr), .rmId(src.rmId), .dlr(ctx.dlr),
		.srOut(srOut), .trapExc(trapExc), .tVal(tVal), .tValid(tValid),
		.unknownIxt(unknownIxt)
	);

	exMemIssue exMemIssue_inst (
		.clock(clock), .cmd(cmd), .ixt(op.ixt), .addr(addr),
		.rmVal(src.rmVal), .rtVal(src.rtVal), .memOk(memOk),
		.memReq(memReq), .memHold(memHold), .isLoad(isLoad)
	);

	exResultMux exResultMux_inst (
		.cmd(cmd), .ixt(op.ixt), .src(src), .addr(addr),
		.tVal(tVal), .tValid(tValid), .branch(branch),
		.memHold(memHold), .isLoad(isLoad), .unknownIxt(unknownIxt),
		.braFlush(braFlush),
		.rn1(rn1), .cn1(cn1), .heldId(heldId), .stall(stall)
	);

endmodule

`default_nettype wire

// File: sim/tbExStage1.sv
/*
 * EX1 stage testbench
 * random micro-ops through the stage, checked by concurrent assertions against a rule model
 */
`timescale 1ns/1ps
`default_nettype none
`include "exStage_defs.svh"

module tbExStage1;
	import exPkg::*;

	localparam int clockPeriod = 40;
	localparam int resetCycles = 16;
	localparam int numTests = 6;
	localparam int opsPerTest = 300;
	localparam int marginCycles = 100;

	logic clock;
	logic rstN;
	exOp_t op;
	exSrc_t src;
	exCtx_t ctx;
	logic braFlush;
	logic [1:0] preBra;
	logic [1:0] memOk;
	exWb_t rn1;
	exWb_t cn1;
	logic [`EX_REGID_W-1:0] heldId;
	logic [`EX_XLEN-1:0] srOut;
	logic [`EX_XLEN-1:0] lrOut;
	logic [15:0] trapExc;
	exMemReq_t memReq;
	exStall_t stall;

	// expected responses
	exUCmd_e effCmd;
	logic [`EX_VALEN-1:0] expAddr;
	logic [`EX_VALEN-1:0] braLo;
	logic [`EX_XLEN-1:0] braTarget;
	logic [`EX_XLEN-1:0] jmpTarget;
	logic [`EX_XLEN-1:0] expTarget;
	logic expDoBra;
	exWb_t expRn1;
	exWb_t expCn1;
	logic [`EX_XLEN-1:0] expLr;
	logic [`EX_XLEN-1:0] expSr;
	logic [15:0] expTrap;
	logic [4:0] expOpm;
	logic badIxt;
	logic expHold;
	logic expRegHeld;
	logic [`EX_REGID_W-1:0] expHeldId;

	int wbErrors = 0;
	int braErrors = 0;
	int sysErrors = 0;
	int memErrors = 0;
	int holdErrors = 0;
	int resetErrors = 0;
	logic jqMode;

	exUCmd_e braCmds [0:3] = '{BRA, BSR, JMP, JSR};
	exUCmd_e memCmds [0:3] = '{MOV_RM, MOV_MR, OP_IXS, ALU3};
	exUCmd_e oddCmds [0:5] = '{INVOP, OP_IXT, OP_IXS, MOV_IR, MOV_CR, NOP};
	logic [7:0] sysIxt [0:9] = '{8'(`EX_IXT_CLRT), 8'(`EX_IXT_SETT), 8'(`EX_IXT_CLRS),
		8'(`EX_IXT_SETS), 8'(`EX_IXT_NOTT), 8'(`EX_IXT_NOTS), 8'(`EX_IXT_RTE),
		8'(`EX_IXT_TRAPA), 8'(`EX_IXT_SYSE), 8'(`EX_IXT_NOP)};

	exStage1 exStage1_inst (
		.clock(clock), .rstN(rstN), .op(op), .src(src), .ctx(ctx),
		.braFlush(braFlush), .preBra(preBra), .memOk(memOk),
		.rn1(rn1), .cn1(cn1), .heldId(heldId), .srOut(srOut), .lrOut(lrOut),
		.trapExc(trapExc), .memReq(memReq), .stall(stall)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	// enable rule, then the not-taken conversion of a skipped BRA
	function automatic exUCmd_e gateCommand(input exOp_t o, input logic t, input logic flush);
		logic en;
		en = (o.cc == AL) || ((o.cc == CT) && t) || ((o.cc == CF) && !t);
		if (en && !flush)
			return o.cmd;
		if ((o.cmd == BRA) && !flush)
			return BRA_NB;
		return NOP;
	endfunction

	// immediate shifted into the low bits of Rs
	function automatic logic [63:0] shiftInImm(input logic [63:0] rs, input logic [63:0] rt,
		input logic [3:0] sel);
		case (sel)
			4'h1: return (rs << 8) | (rt & 64'hFF);
			4'h2: return (rs << 16) | (rt & 64'hFFFF);
			4'h3: return (rs << 32) | (rt & 64'hFFFF_FFFF);
			default: return rt;
		endcase
	endfunction

	always_comb begin
		effCmd = gateCommand(op, ctx.sr[0], braFlush);
		expAddr = src.rsVal[`EX_VALEN-1:0] + (src.rtVal[`EX_VALEN-1:0] << op.ixt[5:4]);
		// segment from the pc while the mode bit is clear
		if (!ctx.sr[31])
			expAddr[`EX_VALEN-1:32] = ctx.pc[`EX_VALEN-1:32];

		expRn1.id = `EX_GR_ZZR;
		expRn1.value = '0;
		case (effCmd)
			LEA: expRn1 = {src.rmId, 16'h0000, expAddr};
			MOV_CR: expRn1 = {src.rmId, src.crmVal};
			MOV_IR: expRn1 = {src.rmId, shiftInImm(src.rsVal, src.rtVal, op.ixt[3:0])};
			OP_IXS: begin
				if (op.ixt[5:0] == `EX_IXS_MOVT)
					expRn1 = {src.rmId, 63'h0, ctx.sr[0]};
				else if (op.ixt[5:0] == `EX_IXS_MOVNT)
					expRn1 = {src.rmId, 63'h0, ~ctx.sr[0]};
			end
			default: ;
		endcase

		// displacement in Rt counts halfwords
		braLo = ctx.pc[`EX_VALEN-1:0] + (src.rtVal[`EX_VALEN-1:0] << 1);
		braTarget = {ctx.pc[63:48], braLo};
		jmpTarget = {(src.rsId == `EX_GR_LR) ? src.rsVal[63:48] : ctx.pc[63:48],
			src.rsVal[47:0]};
		case (effCmd)
			BRA, BSR: expTarget = braTarget;
			JMP, JSR: expTarget = jmpTarget;
			default: expTarget = ctx.pc;
		endcase
		expDoBra = (((effCmd == BRA) || (effCmd == BSR) || (effCmd == JMP)) && (preBra != 2'b01))
			|| ((effCmd == BRA_NB) && (preBra != 2'b00)) || (effCmd == JSR);
		expCn1 = expDoBra ? {`EX_CR_PC, expTarget} : {`EX_GR_ZZR, 64'h0};
		expLr = ((effCmd == BSR) || (effCmd == JSR)) ? ctx.pc : ctx.lr;
		if (braFlush) begin
			expRn1.id = `EX_GR_ZZR;
			expCn1.id = `EX_GR_ZZR;
		end

		expSr = ctx.sr;
		expTrap = 16'h0000;
		badIxt = 1'b0;
		if (effCmd == OP_IXT) begin
			case (op.ixt[5:0])
				`EX_IXT_NOP: ;
				`EX_IXT_CLRT: expSr[0] = 1'b0;
				`EX_IXT_SETT: expSr[0] = 1'b1;
				`EX_IXT_NOTT: expSr[0] = ~ctx.sr[0];
				`EX_IXT_CLRS: expSr[1] = 1'b0;
				`EX_IXT_SETS: expSr[1] = 1'b1;
				`EX_IXT_NOTS: expSr[1] = ~ctx.sr[1];
				`EX_IXT_RTE: expTrap = 16'hFF00;
				`EX_IXT_TRAPA: expTrap = {12'hC08, src.rmId[3:0]};
				`EX_IXT_SYSE: expTrap = {4'hE, ctx.dlr[11:0]};
				default: badIxt = 1'b1;
			endcase
		end
		if ((effCmd == OP_IXS) && !(op.ixt[5:0] inside {`EX_IXS_NOP, `EX_IXS_MOVT,
			`EX_IXS_MOVNT, `EX_IXS_TRAPB}))
			badIxt = 1'b1;

		case (effCmd)
			MOV_RM: expOpm = {2'b10, op.ixt[2], op.ixt[5:4]};
			MOV_MR: expOpm = {2'b01, op.ixt[2], op.ixt[5:4]};
			OP_IXS: expOpm = (op.ixt[5:0] == `EX_IXS_TRAPB) ? `EX_OPM_TRAP : `EX_OPM_READY;
			default: expOpm = `EX_OPM_READY;
		endcase
		expHold = (effCmd == INVOP) || badIxt
			|| ((expOpm != `EX_OPM_READY) && (memOk == `EX_MEMOK_HOLD));
		expRegHeld = (effCmd == MOV_MR) || (effCmd == ALU3);
		expHeldId = expRegHeld ? src.rmId : `EX_GR_ZZR;
	end

	// LEA result depends on the delayed mode flag
	gprWbCheck: assert property (@(posedge clock) disable iff (!rstN)
		((effCmd != LEA) || $stable(ctx.sr[31])) |-> (rn1 == expRn1))
		else begin
			wbErrors++;
			$display("FAILED predication rn1: expected %h actual %h",
				$sampled(expRn1), $sampled(rn1));
		end

	flushIdCheck: assert property (@(posedge clock) disable iff (!rstN)
		braFlush |-> ((rn1.id == `EX_GR_ZZR) && (cn1.id == `EX_GR_ZZR)))
		else begin
			wbErrors++;
			$display("FAILED flush ids: expected %h actual %h",
				{`EX_GR_ZZR, `EX_GR_ZZR}, $sampled({rn1.id, cn1.id}));
		end

	addrCheck: assert property (@(posedge clock) disable iff (!rstN)
		$stable(ctx.sr[31]) |-> (memReq.addr == expAddr))
		else begin
			memErrors++;
			$display("FAILED address generation: expected %h actual %h",
				$sampled(expAddr), $sampled(memReq.addr));
		end

	ctrlWbCheck: assert property (@(posedge clock) disable iff (!rstN) (cn1 == expCn1))
		else begin
			braErrors++;
			$display("FAILED branch cn1: expected %h actual %h",
				$sampled(expCn1), $sampled(cn1));
		end

	lrCheck: assert property (@(posedge clock) disable iff (!rstN) (lrOut == expLr))
		else begin
			braErrors++;
			$display("FAILED link register: expected %h actual %h",
				$sampled(expLr), $sampled(lrOut));
		end

	srCheck: assert property (@(posedge clock) disable iff (!rstN) (srOut == expSr))
		else begin
			sysErrors++;
			$display("FAILED flag op srOut: expected %h actual %h",
				$sampled(expSr), $sampled(srOut));
		end

	trapCheck: assert property (@(posedge clock) disable iff (!rstN) (trapExc == expTrap))
		else begin
			sysErrors++;
			$display("FAILED trap code: expected %h actual %h",
				$sampled(expTrap), $sampled(trapExc));
		end

	opmCheck: assert property (@(posedge clock) disable iff (!rstN) (memReq.opm == expOpm))
		else begin
			memErrors++;
			$display("FAILED memory opm: expected %h actual %h",
				$sampled(expOpm), $sampled(memReq.opm));
		end

	dataCheck: assert property (@(posedge clock) disable iff (!rstN)
		((memReq.data == src.rmVal) && (memReq.dataB == src.rtVal)))
		else begin
			memErrors++;
			$display("FAILED store data: expected %h actual %h",
				$sampled({src.rmVal, src.rtVal}), $sampled({memReq.data, memReq.dataB}));
		end

	heldCheck: assert property (@(posedge clock) disable iff (!rstN)
		({stall.regHeld, heldId} == {expRegHeld, expHeldId}))
		else begin
			memErrors++;
			$display("FAILED held destination: expected %h actual %h",
				$sampled({expRegHeld, expHeldId}), $sampled({stall.regHeld, heldId}));
		end

	holdCheck: assert property (@(posedge clock) disable iff (!rstN) (stall.exHold == expHold))
		else begin
			holdErrors++;
			$display("FAILED exHold: expected %h actual %h",
				$sampled(expHold), $sampled(stall.exHold));
		end

	// a NOP is held on the inputs through reset
	resetQuietCheck: assert property (@(posedge clock)
		!rstN |-> ((cn1.id == `EX_GR_ZZR) && (trapExc == 16'h0000)
			&& (memReq.opm == `EX_OPM_READY) && !stall.exHold))
		else begin
			resetErrors++;
			$display("FAILED reset quiet outputs: expected %h actual %h",
				{`EX_GR_ZZR, 16'h0000, `EX_OPM_READY, 1'b0},
				$sampled({cn1.id, trapExc, memReq.opm, stall.exHold}));
		end

	// fresh random operands each op, pc and Rs kept even
	task automatic issueOp(input exUCmd_e cmd, input logic [7:0] ixt, input exCc_e cc,
		input logic flush);
		exSrc_t s;
		exCtx_t c;
		s.rsId = ($urandom_range(3) == 0) ? `EX_GR_LR : 6'($urandom);
		s.rtId = 6'($urandom);
		s.rmId = 6'($urandom);
		s.rsVal = {$urandom, $urandom} & ~64'h1;
		s.rtVal = {$urandom, $urandom};
		s.rmVal = {$urandom, $urandom};
		s.crmVal = {$urandom, $urandom};
		c.pc = {$urandom, $urandom} & ~64'h1;
		c.sr = {$urandom, $urandom};
		c.sr[31] = jqMode;
		c.dlr = {$urandom, $urandom};
		c.lr = {$urandom, $urandom};
		@(posedge clock);
		op <= {cc, cmd, ixt};
		src <= s;
		ctx <= c;
		braFlush <= flush;
		preBra <= 2'($urandom);
		memOk <= 2'($urandom);
	endtask

	initial begin
		#((resetCycles + numTests * opsPerTest + marginCycles) * clockPeriod);
		$display("watchdog timeout, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		int k;
		int total;
		void'($urandom(32'hb9fa_5b80));
		jqMode = 1'b0;
		rstN <= 1'b0;
		op <= {AL, NOP, 8'h00};
		src <= '0;
		ctx <= '0;
		braFlush <= 1'b0;
		preBra <= 2'b00;
		memOk <= 2'b00;
		repeat (resetCycles) @(posedge clock);
		rstN <= 1'b1;

		// predication and flush on LEA
		for (int i = 0; i < opsPerTest; i++)
			issueOp(LEA, 8'($urandom), exCc_e'($urandom_range(3)), $urandom_range(3) == 0);

		// address mode bit flips now and then
		for (int i = 0; i < opsPerTest; i++) begin
			if ($urandom_range(7) == 0)
				jqMode = ~jqMode;
			issueOp(($urandom_range(1) == 1) ? LEA : MOV_RM, 8'($urandom), AL, 1'b0);
		end

		// disabled BRA turns into BRA_NB
		for (int i = 0; i < opsPerTest; i++)
			issueOp(braCmds[$urandom_range(3)], 8'h00, exCc_e'($urandom_range(3)),
				$urandom_range(7) == 0);

		// flag ops, traps, MOVT and MOVNT
		for (int i = 0; i < opsPerTest; i++) begin
			k = $urandom_range(11);
			if (k < 10)
				issueOp(OP_IXT, sysIxt[k], AL, 1'b0);
			else
				issueOp(OP_IXS, (k == 10) ? 8'(`EX_IXS_MOVT) : 8'(`EX_IXS_MOVNT), AL, 1'b0);
		end

		// loads, stores, TRAPB and ALU3 against random memOk
		for (int i = 0; i < opsPerTest; i++) begin
			k = $urandom_range(3);
			issueOp(memCmds[k], (k == 2) ? 8'(`EX_IXS_TRAPB) : 8'($urandom), AL, 1'b0);
		end

		// invalid ops, unknown sub-ops, immediates and CR moves
		for (int i = 0; i < opsPerTest; i++) begin
			k = $urandom_range(5);
			issueOp(oddCmds[k], (k == 3) ? 8'($urandom_range(3)) : 8'($urandom), AL, 1'b0);
		end

		@(posedge clock);
		op <= {AL, NOP, 8'h00};
		braFlush <= 1'b0;
		repeat (2) @(posedge clock);
		#1;
		total = wbErrors + braErrors + sysErrors + memErrors + holdErrors + resetErrors;
		$display("errors: writeback %0d, branch %0d, system %0d, memory %0d, hold %0d, reset %0d",
			wbErrors, braErrors, sysErrors, memErrors, holdErrors, resetErrors);
		if (total == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/exPkg.sv
hdl/exOpGate.sv
hdl/exAgu.sv
hdl/branch/exBranchUnit.sv
hdl/exSysOps.sv
hdl/exMemIssue.sv
hdl/exResultMux.sv
hdl/exStage1.sv
sim/tbExStage1.sv
